//--- verilog/soc_io_pkg.sv
package soc_io_pkg;

  // One write on the I/O bus, a single-cycle strobe
  typedef struct packed {
    logic        en;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
  } io_wr_t;

  // Read request, answered on io_rdata in the next cycle
  typedef struct packed {
    logic        en;
    logic [31:0] addr;
  } io_rd_req_t;

  // Register map, one word each in a 4-word window
  localparam logic [31:0] ADDR_LED = 32'h0000_0000;
  localparam logic [31:0] ADDR_GPIO = 32'h0000_0004;
  localparam logic [31:0] ADDR_UART_DATA = 32'h0000_0008;
  localparam logic [31:0] ADDR_UART_STATUS = 32'h0000_000C;

  // Status word bits
  localparam int STAT_FULL = 0;
  localparam int STAT_BUSY = 1;
  localparam int STAT_OVF = 2;

  // Transmit frame phases
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    START = 2'd1,
    DATA  = 2'd2,
    STOP  = 2'd3
  } uart_state_e;

endpackage

//--- verilog/uart_baud_timer.sv
`timescale 1ns/1ps

module uart_baud_timer #(
    parameter int CLOCK_FREQ = 85_250_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,
    input  logic run,
    output logic tick
);
  localparam int DIV = CLOCK_FREQ / BAUD_RATE;
  localparam int CW = (DIV > 2) ? $clog2(DIV) : 1;
  localparam logic [CW-1:0] RELOAD = CW'(DIV - 1);

  logic [CW-1:0] cnt;

  assign tick = run && (cnt == '0);

  // Counter holds while the line is idle and restarts with each frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= RELOAD;
    end else if (restart || tick) begin
      cnt <= RELOAD;
    end else if (run) begin
      cnt <= cnt - 1'b1;
    end
  end

  a_div_min: assert property (@(posedge clk) DIV >= 2)
    else $error("baud divisor %0d is below 2", DIV);

endmodule

//--- verilog/uart_tx_fifo.sv
`timescale 1ns/1ps

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  logic [7:0]                  push_data,
    input  logic                        pop,
    output logic [7:0]                  pop_data,
    output logic [$clog2(FIFO_DEPTH):0] count
);
  localparam int AW = $clog2(FIFO_DEPTH);

  logic [7:0] mem[FIFO_DEPTH];
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;

  // Head of the queue is visible before the pop
  assign pop_data = mem[rptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= push_data;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!rst_n) pop |-> count != '0)
    else $error("pop from empty transmit FIFO");

  a_no_push_full: assert property (
      @(posedge clk) disable iff (!rst_n) push |-> count < FIFO_DEPTH)
    else $error("push into full transmit FIFO");

endmodule

//--- verilog/uart_tx_shift.sv
`timescale 1ns/1ps

module uart_tx_shift (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic [7:0] data,
    input  logic       shift,
    input  logic [1:0] line_sel,
    output logic       txd
);
  import soc_io_pkg::*;

  logic [7:0] sreg;
  logic [7:0] sreg_nxt;
  logic       txd_nxt;

  always_comb begin
    sreg_nxt = sreg;
    if (load) begin
      sreg_nxt = data;
    end else if (shift) begin
      sreg_nxt = {1'b0, sreg[7:1]};
    end
  end

  // line_sel names the phase of the coming cycle
  always_comb begin
    case (line_sel)
      START:   txd_nxt = 1'b0;
      DATA:    txd_nxt = sreg_nxt[0];
      default: txd_nxt = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    sreg <= sreg_nxt;
  end

  // Line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      txd <= 1'b1;
    end else begin
      txd <= txd_nxt;
    end
  end

endmodule

//--- verilog/uart_tx_fsm.sv
`timescale 1ns/1ps

module uart_tx_fsm #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [$clog2(FIFO_DEPTH):0] fifo_count,
    output logic                        pop,
    output logic                        load,
    output logic                        restart,
    input  logic                        tick,
    output logic                        shift,
    output logic                        busy,
    output logic [1:0]                  line_sel
);
  import soc_io_pkg::*;

  uart_state_e state;
  uart_state_e state_nxt;
  logic [2:0]  bit_idx;

  // Frame begins as soon as a byte is queued
  assign pop     = (state == IDLE) && (fifo_count != '0);
  assign load    = pop;
  assign restart = pop;
  assign shift   = (state == DATA) && tick;
  assign busy    = (state != IDLE);

  // Shifter flops the line, so it is told the next phase
  assign line_sel = state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (pop) state_nxt = START;
      end
      START: begin
        if (tick) state_nxt = DATA;
      end
      DATA: begin
        if (tick && bit_idx == 3'd7) state_nxt = STOP;
      end
      STOP: begin
        if (tick) state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      bit_idx <= '0;
    end else begin
      state <= state_nxt;
      if (state == START) begin
        bit_idx <= '0;
      end else if (shift) begin
        bit_idx <= bit_idx + 3'd1;
      end
    end
  end

  // A restarted timer waits a full bit before its first tick
  a_restart_no_tick: assert property (
      @(posedge clk) disable iff (!rst_n) restart |=> !tick)
    else $error("baud tick right after a timer restart");

  // Timer runs only while a frame is on the line
  a_no_idle_tick: assert property (
      @(posedge clk) disable iff (!rst_n) state == IDLE |-> !tick)
    else $error("baud tick while idle");

endmodule

//--- verilog/soc_io_regs.sv
`timescale 1ns/1ps

module soc_io_regs #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  soc_io_pkg::io_wr_t          io_wr,
    input  soc_io_pkg::io_rd_req_t      io_rd,
    output logic [31:0]                 io_rdata,
    output logic                        led,
    output logic [7:0]                  gpio,
    output logic                        push,
    output logic [7:0]                  push_data,
    input  logic [$clog2(FIFO_DEPTH):0] fifo_count,
    input  logic                        busy
);
  import soc_io_pkg::*;

  logic        full;
  logic        ovf;
  logic        wr_led;
  logic        wr_gpio;
  logic        wr_data;
  logic        wr_stat;
  logic [31:0] status;
  logic [31:0] rd_word;

  // Byte offset bits are ignored
  function automatic logic hit(input logic [31:0] addr, input logic [31:0] base);
    hit = (addr[31:2] == base[31:2]);
  endfunction

  assign full = (fifo_count == FIFO_DEPTH);

  // Every register sits in byte lane 0
  assign wr_led  = io_wr.en && io_wr.strb[0] && hit(io_wr.addr, ADDR_LED);
  assign wr_gpio = io_wr.en && io_wr.strb[0] && hit(io_wr.addr, ADDR_GPIO);
  assign wr_data = io_wr.en && io_wr.strb[0] && hit(io_wr.addr, ADDR_UART_DATA);
  assign wr_stat = io_wr.en && io_wr.strb[0] && hit(io_wr.addr, ADDR_UART_STATUS);

  assign push      = wr_data && !full;
  assign push_data = io_wr.data[7:0];

  // Queued bytes count as busy so polling waits for the last stop bit
  always_comb begin
    status            = '0;
    status[STAT_FULL] = full;
    status[STAT_BUSY] = busy || (fifo_count != '0);
    status[STAT_OVF]  = ovf;
  end

  // UART_DATA is write only and reads as zero
  always_comb begin
    rd_word = '0;
    if (hit(io_rd.addr, ADDR_LED)) begin
      rd_word = {31'b0, led};
    end else if (hit(io_rd.addr, ADDR_GPIO)) begin
      rd_word = {24'b0, gpio};
    end else if (hit(io_rd.addr, ADDR_UART_STATUS)) begin
      rd_word = status;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led      <= 1'b0;
      gpio     <= '0;
      ovf      <= 1'b0;
      io_rdata <= '0;
    end else begin
      if (wr_led) begin
        led <= io_wr.data[0];
      end
      if (wr_gpio) begin
        gpio <= io_wr.data[7:0];
      end
      // Sticky until software writes a one to clear it
      if (wr_data && full) begin
        ovf <= 1'b1;
      end else if (wr_stat && io_wr.data[STAT_OVF]) begin
        ovf <= 1'b0;
      end
      if (io_rd.en) begin
        io_rdata <= rd_word;
      end
    end
  end

  a_push_not_full: assert property (
      @(posedge clk) disable iff (!rst_n)
      push |-> (fifo_count < FIFO_DEPTH) ##1 (fifo_count != '0))
    else $error("push while transmit FIFO full");

endmodule

//--- verilog/soc_io_top.sv
`timescale 1ns/1ps

module soc_io_top #(
    parameter int CLOCK_FREQ = 85_250_000,
    parameter int BAUD_RATE  = 115_200,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  soc_io_pkg::io_wr_t     io_wr,
    input  soc_io_pkg::io_rd_req_t io_rd,
    output logic [31:0]            io_rdata,
    output logic                   led,
    output logic [7:0]             gpio,
    output logic                   uart_tx
);
  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  logic             push;
  logic [7:0]       push_data;
  logic [CNT_W-1:0] fifo_count;
  logic             pop;
  logic [7:0]       pop_data;
  logic             load;
  logic             restart;
  logic             tick;
  logic             shift;
  logic             busy;
  logic [1:0]       line_sel;

  soc_io_regs #(
      .FIFO_DEPTH(FIFO_DEPTH)
  ) regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .io_wr     (io_wr),
      .io_rd     (io_rd),
      .io_rdata  (io_rdata),
      .led       (led),
      .gpio      (gpio),
      .push      (push),
      .push_data (push_data),
      .fifo_count(fifo_count),
      .busy      (busy)
  );

  uart_tx_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
  ) tx_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push),
      .push_data(push_data),
      .pop      (pop),
      .pop_data (pop_data),
      .count    (fifo_count)
  );

  uart_tx_fsm #(
      .FIFO_DEPTH(FIFO_DEPTH)
  ) tx_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .fifo_count(fifo_count),
      .pop       (pop),
      .load      (load),
      .restart   (restart),
      .tick      (tick),
      .shift     (shift),
      .busy      (busy),
      .line_sel  (line_sel)
  );

  // Timer runs for the whole frame
  uart_baud_timer #(
      .CLOCK_FREQ(CLOCK_FREQ),
      .BAUD_RATE (BAUD_RATE)
  ) baud (
      .clk    (clk),
      .rst_n  (rst_n),
      .restart(restart),
      .run    (busy),
      .tick   (tick)
  );

  uart_tx_shift tx_shift (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .data    (pop_data),
      .shift   (shift),
      .line_sel(line_sel),
      .txd     (uart_tx)
  );

endmodule

//--- bench/soc_io_tb.sv
`timescale 1ns/1ps

module soc_io_tb;
  import soc_io_pkg::*;

  localparam int CLK_HZ = 10_000_000;
  localparam int BAUD = 1_000_000;
  localparam int DEPTH = 4;
  localparam int BIT_CYC = CLK_HZ / BAUD;
  localparam int WAIT_MAX = 2000;
  localparam int NSTEPS = 10;
  localparam logic [31:0] FULL_BUSY = (32'd1 << STAT_FULL) | (32'd1 << STAT_BUSY);
  localparam logic [31:0] OVF_BIT = 32'd1 << STAT_OVF;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp;
  } step_t;

  // Reads carry the expected word, writes are followed by a pin check
  localparam step_t STEPS[NSTEPS] = '{
    '{1'b1, ADDR_GPIO, 32'h0000_005A, 4'h1, 32'h0},
    '{1'b0, ADDR_GPIO, 32'h0, 4'h0, 32'h0000_005A},
    '{1'b1, ADDR_GPIO, 32'h0000_00FF, 4'hE, 32'h0},
    '{1'b0, ADDR_GPIO, 32'h0, 4'h0, 32'h0000_005A},
    '{1'b1, ADDR_LED, 32'h0000_0001, 4'h1, 32'h0},
    '{1'b0, ADDR_LED, 32'h0, 4'h0, 32'h0000_0001},
    '{1'b1, ADDR_GPIO, 32'h1234_56C3, 4'hF, 32'h0},
    '{1'b0, ADDR_GPIO, 32'h0, 4'h0, 32'h0000_00C3},
    '{1'b0, 32'h0000_0010, 32'h0, 4'h0, 32'h0},
    '{1'b0, 32'h0000_0100, 32'h0, 4'h0, 32'h0}
  };

  logic        clk;
  logic        rst_n;
  io_wr_t      io_wr;
  io_rd_req_t  io_rd;
  logic [31:0] io_rdata;
  logic        led;
  logic [7:0]  gpio;
  logic        uart_tx;

  int         errors;
  int         test_errs;
  int         tests_failed;
  logic [7:0] rx_q[$];
  logic [7:0] sent_q[$];

  soc_io_top #(
      .CLOCK_FREQ(CLK_HZ),
      .BAUD_RATE (BAUD),
      .FIFO_DEPTH(DEPTH)
  ) DUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .io_wr   (io_wr),
      .io_rd   (io_rd),
      .io_rdata(io_rdata),
      .led     (led),
      .gpio    (gpio),
      .uart_tx (uart_tx)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
      end
  endtask

  task automatic timeout_error(input string why);
    $display("%0t ns: %s", $time, why);
    errors++;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    io_wr = '{1'b1, addr, data, strb};
    @(posedge clk);
    #1;
    io_wr.en = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    io_rd = '{1'b1, addr};
    @(posedge clk);
    #1;
    io_rd.en = 1'b0;
    data = io_rdata;
  endtask

  // Polls the status word until the last stop bit is out
  task automatic wait_idle();
    logic [31:0] st;
    int n;
    n = 0;
    bus_read(ADDR_UART_STATUS, st);
    while (st[STAT_BUSY] && n < WAIT_MAX) begin
      n++;
      bus_read(ADDR_UART_STATUS, st);
    end
    if (st[STAT_BUSY]) timeout_error("transmitter still busy after the timeout");
  endtask

  task automatic wait_start(output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (uart_tx !== 1'b0 && n < WAIT_MAX);
    if (uart_tx !== 1'b0) timeout_error("no start bit on uart_tx before the timeout");
  endtask

  task automatic check_rx(input string name);
    check({name, " byte count"}, rx_q.size(), sent_q.size());
    for (int i = 0; i < sent_q.size() && i < rx_q.size(); i++) begin
      check($sformatf("%s byte %0d", name, i), rx_q[i], sent_q[i]);
    end
    rx_q.delete();
    sent_q.delete();
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_errs) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - test_errs);
      tests_failed++;
    end
    test_errs = errors;
  endtask

  // Samples the serial line near the middle of each bit
  initial begin : line_monitor
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) begin
        repeat (BIT_CYC / 2 - 1) @(negedge clk);
        check("uart_tx at start bit center", uart_tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CYC) @(negedge clk);
          b[i] = uart_tx;
        end
        repeat (BIT_CYC) @(negedge clk);
        check("uart_tx at stop bit center", uart_tx, 1'b1);
        rx_q.push_back(b);
      end
    end
  end

  initial begin : cpu
    logic [31:0] rd;
    logic [10:0] frame;
    logic [7:0]  b;
    logic        led_m;
    logic [7:0]  gpio_m;
    int          n;
    void'($urandom(91));
    errors = 0;
    test_errs = 0;
    tests_failed = 0;
    io_wr = '0;
    io_rd = '0;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check("led", led, 0);
    check("gpio", gpio, 0);
    check("io_rdata", io_rdata, 0);
    check("uart_tx", uart_tx, 1);
    bus_read(ADDR_UART_STATUS, rd);
    check("status", rd, 0);
    end_test(1, "reset values");

    led_m = 1'b0;
    gpio_m = '0;
    for (int i = 0; i < NSTEPS; i++) begin
      if (STEPS[i].wr) begin
        bus_write(STEPS[i].addr, STEPS[i].data, STEPS[i].strb);
        if (STEPS[i].strb[0] && STEPS[i].addr == ADDR_LED) led_m = STEPS[i].data[0];
        if (STEPS[i].strb[0] && STEPS[i].addr == ADDR_GPIO) gpio_m = STEPS[i].data[7:0];
        check("led", led, led_m);
        check("gpio", gpio, gpio_m);
      end else begin
        bus_read(STEPS[i].addr, rd);
        check($sformatf("io_rdata from %h", STEPS[i].addr), rd, STEPS[i].exp);
      end
    end
    end_test(2, "LED and GPIO byte strobes");

    bus_write(ADDR_UART_DATA, 32'h0000_00A5, 4'h1);
    sent_q.push_back(8'hA5);
    wait_start(n);
    check("cycles from write to start bit", n, 2);
    // Bit 0 is the start bit, bit 9 the stop bit, bit 10 the idle line
    frame = {2'b11, 8'hA5, 1'b0};
    for (int j = 0; j <= 10 * BIT_CYC; j++) begin
      if (j > 0) @(negedge clk);
      check($sformatf("uart_tx in frame cycle %0d", j), uart_tx, frame[j / BIT_CYC]);
    end
    wait_idle();
    check_rx("single");
    end_test(3, "single byte transmit");

    // One byte leaves for the shifter at once, so depth plus one writes fill the queue
    for (int i = 0; i <= DEPTH; i++) begin
      b = 8'(8'h3C + 17 * i);
      bus_write(ADDR_UART_DATA, {24'h0, b}, 4'h1);
      sent_q.push_back(b);
    end
    bus_read(ADDR_UART_STATUS, rd);
    check("status after queue fill", rd, FULL_BUSY);
    wait_idle();
    check_rx("back-to-back");
    end_test(4, "back-to-back queue");

    for (int i = 0; i <= DEPTH + 1; i++) begin
      b = 8'(8'h81 + 29 * i);
      bus_write(ADDR_UART_DATA, {24'h0, b}, 4'h1);
      if (i <= DEPTH) sent_q.push_back(b);
    end
    bus_read(ADDR_UART_STATUS, rd);
    check("status after overflow", rd, FULL_BUSY | OVF_BIT);
    bus_write(ADDR_UART_STATUS, OVF_BIT, 4'h1);
    bus_read(ADDR_UART_STATUS, rd);
    check("status after overflow clear", rd, FULL_BUSY);
    wait_idle();
    bus_read(ADDR_UART_STATUS, rd);
    check("status when idle", rd, 0);
    check_rx("overflow");
    end_test(5, "overflow flag");

    for (int i = 0; i < 8; i++) begin
      b = 8'($urandom);
      n = 0;
      bus_read(ADDR_UART_STATUS, rd);
      while (rd[STAT_FULL] && n < WAIT_MAX) begin
        n++;
        bus_read(ADDR_UART_STATUS, rd);
      end
      if (rd[STAT_FULL]) timeout_error("STAT_FULL did not clear before the timeout");
      bus_write(ADDR_UART_DATA, {24'h0, b}, 4'h1);
      sent_q.push_back(b);
    end
    wait_idle();
    check_rx("random");
    end_test(6, "random bytes");

    $display("6 tests run, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/soc_io_pkg.sv
verilog/uart_baud_timer.sv
verilog/uart_tx_fifo.sv
verilog/uart_tx_shift.sv
verilog/uart_tx_fsm.sv
verilog/soc_io_regs.sv
verilog/soc_io_top.sv
bench/soc_io_tb.sv

//--- Makefile
# Verilator build and run for the SoC I/O testbench

VERILATOR ?= verilator
TOP       ?= soc_io_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
